//--- sources.f
+incdir+logic
logic/csr_pkg.sv
logic/sys_decode.sv
logic/csr_file.sv
logic/csr_unit.sv
verif/csr_unit_checker.sv
verif/csr_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the csr_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module csr_unit_tb -f sources.f \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/Vcsr_unit_tb 2>&1)
echo "$sim_out"

# the run passes only if the testbench printed its pass line
echo "$sim_out" | grep -qx "Finished with no errors" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_tb;

    localparam time clk_period      = 100ns;
    localparam int  reset_cycles    = 10;
    localparam int  num_tests       = 6;
    localparam int  cycles_per_test = 200;

    // funct3 of the CSR instructions
    localparam logic [2:0] f3_rw  = 3'b001;
    localparam logic [2:0] f3_rs  = 3'b010;
    localparam logic [2:0] f3_rc  = 3'b011;
    localparam logic [2:0] f3_rwi = 3'b101;
    localparam logic [2:0] f3_rsi = 3'b110;
    localparam logic [2:0] f3_rci = 3'b111;

    logic            clk;
    logic            reset;
    logic            en;
    csr_pkg::xlen_t  pc;
    csr_pkg::instr_t instr;
    csr_pkg::xlen_t  rs1_data;
    logic            ready;
    csr_pkg::xlen_t  rd_data;
    logic            redirect;
    csr_pkg::xlen_t  target_pc;
    logic            illegal;

    // expected CSRs: mstatus, mtvec, mepc, mcause, mscratch
    csr_pkg::xlen_t model_csr [`NUM_CSR];

    // answer captured at the falling edge that shows ready
    csr_pkg::xlen_t got_rd;
    csr_pkg::xlen_t got_target;
    logic           got_redirect;
    logic           got_illegal;
    int             got_latency;

    integer seed;

    csr_unit i_csr_unit (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .pc        (pc),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .ready     (ready),
        .rd_data   (rd_data),
        .redirect  (redirect),
        .target_pc (target_pc),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // architectural address of a storage slot
    function automatic logic [11:0] csr_address(input int slot);
        case (slot)
            0: return 12'h300;
            1: return 12'h305;
            2: return 12'h341;
            3: return 12'h342;
            default: return 12'h340;
        endcase
    endfunction

    // SYSTEM instruction, rd is x5
    function automatic csr_pkg::instr_t encode_csr(input logic [11:0] addr,
                                                   input logic [4:0] rs1_field,
                                                   input logic [2:0] funct3);
        return {addr, rs1_field, funct3, 5'd5, 7'b111_0011};
    endfunction

    function automatic csr_pkg::xlen_t random_word();
        csr_pkg::xlen_t value;
        value = {$random(seed), $random(seed)};
        return value;
    endfunction

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_value(input string what, input csr_pkg::xlen_t got,
                                input csr_pkg::xlen_t exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic expect_flag(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    // ready must show one cycle after en is sampled
    task automatic expect_latency(input string what);
        assert (got_latency == 1) else begin
            $display("mismatch at %0d ns: %s answered after %0d cycles, expected 1",
                     $time, what, got_latency);
            fail_run();
        end
    endtask

    // raise en, hold it until ready, drop it at that falling edge
    task automatic issue(input csr_pkg::instr_t word, input csr_pkg::xlen_t rs1_val,
                         input csr_pkg::xlen_t at_pc);
        @(negedge clk);
        en          = 1'b1;
        instr       = word;
        rs1_data    = rs1_val;
        pc          = at_pc;
        got_latency = 0;
        do begin
            @(negedge clk);
            got_latency++;
        end while (ready !== 1'b1);
        got_rd       = rd_data;
        got_target   = target_pc;
        got_redirect = redirect;
        got_illegal  = illegal;
        en           = 1'b0;
    endtask

    // one CSR instruction, checked and applied to the model
    task automatic csr_access(input logic [2:0] funct3, input int slot,
                              input logic [4:0] rs1_field, input csr_pkg::xlen_t rs1_val);
        csr_pkg::xlen_t operand;
        csr_pkg::xlen_t old_val;
        operand = funct3[2] ? csr_pkg::xlen_t'(rs1_field) : rs1_val;
        old_val = model_csr[slot];
        issue(encode_csr(csr_address(slot), rs1_field, funct3), rs1_val, '0);
        expect_latency("csr instruction");
        expect_value("rd_data", got_rd, old_val);
        expect_flag("illegal", got_illegal, 1'b0);
        expect_flag("redirect", got_redirect, 1'b0);
        // set and clear write even with a zero source
        case (funct3[1:0])
            2'b01:   model_csr[slot] = operand;
            2'b10:   model_csr[slot] = old_val | operand;
            default: model_csr[slot] = old_val & ~operand;
        endcase
    endtask

    task automatic read_all();
        for (int slot = 0; slot < `NUM_CSR; slot++) begin
            csr_access(f3_rs, slot, 5'd0, '0);
        end
    endtask

    task automatic expect_illegal(input string what);
        expect_latency(what);
        expect_flag({what, " illegal"}, got_illegal, 1'b1);
        expect_flag({what, " redirect"}, got_redirect, 1'b0);
    endtask

    task automatic test_reset_values();
        expect_flag("ready after reset", ready, 1'b0);
        expect_flag("redirect after reset", redirect, 1'b0);
        expect_flag("illegal after reset", illegal, 1'b0);
        expect_value("rd_data after reset", rd_data, '0);
        // csrrs with x0 reads without changing anything
        read_all();
    endtask

    task automatic test_scratch_write();
        csr_pkg::xlen_t value;
        value = random_word();
        csr_access(f3_rw, 4, 5'd1, value);
        csr_access(f3_rs, 4, 5'd0, '0);
        expect_value("mscratch readback", got_rd, value);
    endtask

    task automatic test_set_clear();
        logic [2:0] forms [5];
        int         slot;
        // csrrwi rides along to cover the immediate write form
        forms = '{f3_rs, f3_rc, f3_rsi, f3_rci, f3_rwi};
        for (int round = 0; round < 3; round++) begin
            foreach (forms[k]) begin
                slot = ($random(seed) & 32'h7fff_ffff) % `NUM_CSR;
                csr_access(forms[k], slot, 5'($random(seed)), random_word());
            end
        end
        read_all();
    endtask

    task automatic test_ecall();
        csr_pkg::xlen_t handler;
        csr_pkg::xlen_t trap_pc;
        handler = random_word() & ~64'h3;
        trap_pc = random_word() & ~64'h3;
        csr_access(f3_rw, 1, 5'd1, handler);
        issue(32'h0000_0073, random_word(), trap_pc);
        expect_latency("ecall");
        expect_flag("ecall redirect", got_redirect, 1'b1);
        expect_flag("ecall illegal", got_illegal, 1'b0);
        expect_value("ecall target_pc", got_target, handler);
        model_csr[2] = trap_pc;
        model_csr[3] = 64'd11;
        csr_access(f3_rs, 2, 5'd0, '0);
        expect_value("mepc after ecall", got_rd, trap_pc);
        csr_access(f3_rs, 3, 5'd0, '0);
        expect_value("mcause after ecall", got_rd, 64'd11);
    endtask

    task automatic test_mret();
        csr_pkg::xlen_t ret_pc;
        ret_pc = random_word() & ~64'h3;
        csr_access(f3_rw, 2, 5'd1, ret_pc);
        issue(32'h3020_0073, '0, random_word());
        expect_latency("mret");
        expect_flag("mret redirect", got_redirect, 1'b1);
        expect_flag("mret illegal", got_illegal, 1'b0);
        expect_value("mret target_pc", got_target, ret_pc);
    endtask

    task automatic test_illegal();
        csr_pkg::xlen_t junk;
        junk = random_word();
        // mie is not implemented
        issue(encode_csr(12'h304, 5'd1, f3_rw), junk, '0);
        expect_illegal("unknown csr");
        // wfi shares funct3 000 with ecall and mret
        issue(32'h1050_0073, junk, junk);
        expect_illegal("wfi");
        issue(encode_csr(12'h300, 5'd1, 3'b100), junk, '0);
        expect_illegal("reserved funct3");
        read_all();
    endtask

    initial begin
        seed     = 32'h1332_9d9c;
        reset    = 1'b1;
        en       = 1'b0;
        pc       = '0;
        instr    = '0;
        rs1_data = '0;
        for (int i = 0; i < `NUM_CSR; i++) begin
            model_csr[i] = '0;
        end
        model_csr[0] = `MSTATUS_RESET;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_values();
        test_scratch_write();
        test_set_clear();
        test_ecall();
        test_mret();
        test_illegal();
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

    // watchdog over reset plus all tests
    initial begin
        #(clk_period * (reset_cycles + num_tests * cycles_per_test));
        $display("timeout: the DUT did not finish the tests in the allowed time");
        fail_run();
    end

endmodule

`default_nettype wire

//--- verif/csr_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker (
    input logic clk,
    input logic reset,
    input logic en,
    input logic ready,
    input logic redirect,
    input logic illegal
);

    // answer pulses last exactly one cycle
    ready_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ready |=> !ready)
        else $error("ready stayed high for more than one cycle");

    // redirect only comes with an answer
    redirect_with_ready: assert property (@(posedge clk) disable iff (reset)
        redirect |-> ready)
        else $error("redirect without ready");

    // an illegal answer never redirects
    illegal_without_redirect: assert property (@(posedge clk) disable iff (reset)
        illegal |-> (ready && !redirect))
        else $error("illegal without ready, or together with redirect");

    // en sampled one cycle before every answer
    ready_after_en: assert property (@(posedge clk) disable iff (reset)
        ready |-> $past(en))
        else $error("ready without a preceding en");

endmodule

bind csr_file csr_unit_checker i_csr_unit_checker (
    .clk      (clk),
    .reset    (reset),
    .en       (en),
    .ready    (ready),
    .redirect (redirect),
    .illegal  (illegal)
);

`default_nettype wire

//--- logic/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            en,
    input  csr_pkg::xlen_t  pc,
    input  csr_pkg::instr_t instr,
    input  csr_pkg::xlen_t  rs1_data,
    output logic            ready,
    output csr_pkg::xlen_t  rd_data,
    output logic            redirect,
    output csr_pkg::xlen_t  target_pc,
    output logic            illegal
);

    // decoder to CSR file
    csr_pkg::sys_op_t  op;
    csr_pkg::csr_idx_t idx;
    csr_pkg::xlen_t    src;
    logic              illegal_instr;

    // combinational decode of the held instruction
    sys_decode i_sys_decode (
        .instr         (instr),
        .rs1_data      (rs1_data),
        .op            (op),
        .idx           (idx),
        .src           (src),
        .illegal_instr (illegal_instr)
    );

    // all state lives here
    csr_file i_csr_file (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .pc            (pc),
        .op            (op),
        .idx           (idx),
        .src           (src),
        .illegal_instr (illegal_instr),
        .ready         (ready),
        .rd_data       (rd_data),
        .redirect      (redirect),
        .target_pc     (target_pc),
        .illegal       (illegal)
    );

endmodule

`default_nettype wire

//--- logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              en,
    input  csr_pkg::xlen_t    pc,
    input  csr_pkg::sys_op_t  op,
    input  csr_pkg::csr_idx_t idx,
    input  csr_pkg::xlen_t    src,
    input  logic              illegal_instr,
    output logic              ready,
    output csr_pkg::xlen_t    rd_data,
    output logic              redirect,
    output csr_pkg::xlen_t    target_pc,
    output logic              illegal
);

    // machine CSR storage, slot order as in csr_pkg
    csr_pkg::xlen_t csr_q [`NUM_CSR];

    csr_pkg::csr_phase_t phase_q;

    logic              ready_q;
    logic              redirect_q;
    logic              illegal_q;
    csr_pkg::xlen_t    rd_data_q;
    csr_pkg::xlen_t    target_pc_q;

    // write-back value and slot held over to the commit cycle
    csr_pkg::xlen_t    pending_q;
    csr_pkg::csr_idx_t commit_idx_q;

    csr_pkg::xlen_t old_val;
    csr_pkg::xlen_t new_val;
    logic           start;

    // a new instruction is only taken from idle
    assign start = en && (phase_q == csr_pkg::ph_idle);

    // old value, slots past the storage read as zero
    assign old_val = (idx < `NUM_CSR) ? csr_q[idx] : '0;

    // read-modify-write result
    always_comb begin
        case (op)
            csr_pkg::op_write: new_val = src;
            csr_pkg::op_set:   new_val = old_val | src;
            csr_pkg::op_clear: new_val = old_val & ~src;
            default:           new_val = old_val;
        endcase
    end

    // FSM, answer flags and CSR storage
    always_ff @(posedge clk) begin
        if (reset) begin
            phase_q    <= csr_pkg::ph_idle;
            ready_q    <= 1'b0;
            redirect_q <= 1'b0;
            illegal_q  <= 1'b0;
            rd_data_q  <= '0;
            for (int i = 0; i < `NUM_CSR; i++) begin
                csr_q[i] <= (i == csr_pkg::idx_mstatus) ? `MSTATUS_RESET : '0;
            end
        end else begin
            // answer flags are single-cycle pulses
            ready_q    <= 1'b0;
            redirect_q <= 1'b0;
            illegal_q  <= 1'b0;
            case (phase_q)
                csr_pkg::ph_idle: begin
                    if (en) begin
                        ready_q <= 1'b1;
                        case (op)
                            csr_pkg::op_write,
                            csr_pkg::op_set,
                            csr_pkg::op_clear: begin
                                // old value out now, write lands next edge
                                rd_data_q <= old_val;
                                phase_q   <= csr_pkg::ph_commit;
                            end
                            csr_pkg::op_ecall: begin
                                // trap entry
                                csr_q[csr_pkg::idx_mepc]   <= pc;
                                csr_q[csr_pkg::idx_mcause] <= csr_pkg::xlen_t'(`ECALL_CAUSE);
                                rd_data_q  <= '0;
                                redirect_q <= 1'b1;
                                phase_q    <= csr_pkg::ph_done;
                            end
                            csr_pkg::op_mret: begin
                                rd_data_q  <= '0;
                                redirect_q <= 1'b1;
                                phase_q    <= csr_pkg::ph_done;
                            end
                            default: begin
                                // op_none, nothing changes
                                rd_data_q <= '0;
                                illegal_q <= illegal_instr;
                                phase_q   <= csr_pkg::ph_done;
                            end
                        endcase
                    end
                end
                csr_pkg::ph_commit: begin
                    csr_q[commit_idx_q] <= pending_q;
                    phase_q <= csr_pkg::ph_idle;
                end
                csr_pkg::ph_done: begin
                    // held en must not restart the instruction
                    if (!en) begin
                        phase_q <= csr_pkg::ph_idle;
                    end
                end
                default: phase_q <= csr_pkg::ph_idle;
            endcase
        end
    end

    // payload captured on acceptance
    always_ff @(posedge clk) begin
        if (start) begin
            pending_q    <= new_val;
            commit_idx_q <= idx;
            // mtvec for ecall, mepc for mret
            if (op == csr_pkg::op_ecall) begin
                target_pc_q <= csr_q[csr_pkg::idx_mtvec];
            end else if (op == csr_pkg::op_mret) begin
                target_pc_q <= csr_q[csr_pkg::idx_mepc];
            end
        end
    end

    assign ready     = ready_q;
    assign rd_data   = rd_data_q;
    assign redirect  = redirect_q;
    assign target_pc = target_pc_q;
    assign illegal   = illegal_q;

endmodule

`default_nettype wire

//--- logic/sys_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sys_decode (
    input  csr_pkg::instr_t   instr,
    input  csr_pkg::xlen_t    rs1_data,
    output csr_pkg::sys_op_t  op,
    output csr_pkg::csr_idx_t idx,
    output csr_pkg::xlen_t    src,
    output logic              illegal_instr
);

    // SYSTEM major opcode
    localparam logic [6:0] opcode_system = 7'b111_0011;

    // privileged instructions, matched on the whole word
    localparam csr_pkg::instr_t ecall_word = 32'h0000_0073;
    localparam csr_pkg::instr_t mret_word  = 32'h3020_0073;

    // architectural CSR addresses
    localparam logic [11:0] addr_mstatus  = 12'h300;
    localparam logic [11:0] addr_mtvec    = 12'h305;
    localparam logic [11:0] addr_mscratch = 12'h340;
    localparam logic [11:0] addr_mepc     = 12'h341;
    localparam logic [11:0] addr_mcause   = 12'h342;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [11:0]       csr_addr;
    logic [4:0]        uimm;
    logic              addr_hit;
    csr_pkg::csr_idx_t addr_idx;

    // instruction fields
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign csr_addr = instr[31:20];
    // rs1 field doubles as the 5-bit immediate
    assign uimm     = instr[19:15];

    // map the 12-bit address onto the compact index
    always_comb begin
        addr_hit = 1'b1;
        addr_idx = csr_pkg::idx_mstatus;
        case (csr_addr)
            addr_mstatus:  addr_idx = csr_pkg::idx_mstatus;
            addr_mtvec:    addr_idx = csr_pkg::idx_mtvec;
            addr_mepc:     addr_idx = csr_pkg::idx_mepc;
            addr_mcause:   addr_idx = csr_pkg::idx_mcause;
            addr_mscratch: addr_idx = csr_pkg::idx_mscratch;
            default:       addr_hit = 1'b0;
        endcase
    end

    assign idx = addr_idx;

    // funct3[2] picks the zero-extended immediate over rs1
    assign src = funct3[2] ? csr_pkg::xlen_t'(uimm) : rs1_data;

    // operation select, anything unmatched stays op_none
    always_comb begin
        op = csr_pkg::op_none;
        if (opcode == opcode_system) begin
            case (funct3)
                3'b000: begin
                    // only the exact ecall and mret words are accepted
                    if (instr == ecall_word) begin
                        op = csr_pkg::op_ecall;
                    end else if (instr == mret_word) begin
                        op = csr_pkg::op_mret;
                    end
                end
                3'b001, 3'b101: begin
                    if (addr_hit) begin
                        op = csr_pkg::op_write;
                    end
                end
                3'b010, 3'b110: begin
                    if (addr_hit) begin
                        op = csr_pkg::op_set;
                    end
                end
                3'b011, 3'b111: begin
                    if (addr_hit) begin
                        op = csr_pkg::op_clear;
                    end
                end
                // funct3 100 is reserved
                default: ;
            endcase
        end
    end

    // legality is decided here alone
    assign illegal_instr = (op == csr_pkg::op_none);

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

`include "csr_cfg.svh"

    // register value or pc
    typedef logic [`XLEN-1:0] xlen_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // compact index into the CSR storage
    typedef logic [2:0] csr_idx_t;

    // storage slots of the implemented CSRs
    localparam csr_idx_t idx_mstatus  = 3'd0;
    localparam csr_idx_t idx_mtvec    = 3'd1;
    localparam csr_idx_t idx_mepc     = 3'd2;
    localparam csr_idx_t idx_mcause   = 3'd3;
    localparam csr_idx_t idx_mscratch = 3'd4;

    // decoded system operation
    typedef enum logic [2:0] {
        // unknown encoding, answered as illegal
        op_none,
        // csrrw / csrrwi
        op_write,
        // csrrs / csrrsi
        op_set,
        // csrrc / csrrci
        op_clear,
        op_ecall,
        op_mret
    } sys_op_t;

    // CSR file FSM
    typedef enum logic [1:0] {
        // waiting for en
        ph_idle,
        // pending read-modify-write value goes into storage
        ph_commit,
        // answered, waiting for en to drop
        ph_done
    } csr_phase_t;

endpackage

`default_nettype wire

//--- logic/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data path width of the core
`define XLEN 64

// implemented machine CSRs: mstatus, mtvec, mepc, mcause, mscratch
`define NUM_CSR 5

// mstatus after reset, mpp = machine, sxl/uxl fields set
`define MSTATUS_RESET 64'h0000_000a_0000_1800

// mcause code of an environment call from machine mode
`define ECALL_CAUSE 11

`endif
